// ==== logic/textVgaPkg.sv ====
package textVgaPkg;

  localparam int CharWidth = 8; // bits per character code

  // raster sequencer states, line states first
  typedef enum logic [3:0] {
    init,   // single cycle after reset
    active,
    hFront,
    hSync,
    hBack,
    vFront, // whole-line states of the vertical blank
    vSync,
    vBack
  } rasterState;

  typedef struct packed {
    logic init;       // high for one cycle out of reset
    logic active;     // visible pixel level
    logic lineEnd;    // strobe at last column of a line
    logic frameStart; // strobe at column 0 of row 0
    logic hsyncLevel; // positive-going
    logic vsyncLevel; // positive-going
  } rasterCtl;

  typedef struct packed {
    logic red;
    logic green;
    logic blue;
    logic hsyncN; // active low
    logic vsyncN; // active low
  } videoOut;

endpackage

// ==== logic/rangeCounter.sv ====
`timescale 1ns/1ps

module rangeCounter #(
  parameter int Min = 0,
  parameter int Max = 255,
  parameter int Inc = 1
) (
  input  logic clk,
  input  logic reset,
  input  logic en,
  output int   count,
  output logic nearFull,
  output logic wrap
);

  always_ff @(posedge clk) begin
    if (reset) begin
      count    <= Min;
      nearFull <= 1'b0;
      wrap     <= 1'b0;
    end else if (en) begin
      nearFull <= (count == Max - Inc); // stepping into Max
      wrap     <= (count == Max);
      count    <= (count == Max) ? Min : count + Inc;
    end else begin
      nearFull <= 1'b0; // strobes last one cycle only
      wrap     <= 1'b0;
    end
  end

endmodule

// ==== logic/delayLine.sv ====
`timescale 1ns/1ps

module delayLine #(
  parameter int Len   = 4,
  parameter int Width = 1
) (
  input  logic             clk,
  input  logic             reset,
  input  logic [Width-1:0] din,
  output logic [Width-1:0] dout
);

  logic [Width-1:0] stages [Len];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < Len; i++) stages[i] <= '0; // inactive syncs out of reset
    end else begin
      stages[0] <= din;
      for (int i = 1; i < Len; i++) stages[i] <= stages[i-1];
    end
  end

  assign dout = stages[Len-1]; // din from Len cycles ago

endmodule

// ==== logic/rasterSequencer.sv ====
`timescale 1ns/1ps

module rasterSequencer #(
  parameter int ScrnCols = 640,
  parameter int ScrnRows = 480,
  parameter int HSynStrt = 656,
  parameter int HSynStop = 720,
  parameter int LineCols = 800,
  parameter int VSynStrt = 483,
  parameter int VSynStop = 487,
  parameter int FramRows = 501
) (
  input  logic                 clk,
  input  logic                 reset,
  input  int                   hctr,
  input  int                   vctr,
  output textVgaPkg::rasterCtl ctl
);
  import textVgaPkg::*;

  rasterState state;
  logic lineEndReg;
  logic frameStartReg;
  logic hsyncReg;

  // last cycle of each interval
  logic activeEnd;
  logic hFrontEnd;
  logic hSyncEnd;
  logic lineLast;
  logic lastVisRow;
  logic vFrontEnd;
  logic vSyncEnd;
  logic frameLast;

  assign activeEnd  = (hctr == ScrnCols - 1);
  assign hFrontEnd  = (hctr == HSynStrt - 1);
  assign hSyncEnd   = (hctr == HSynStop - 1);
  assign lineLast   = (hctr == LineCols - 1);
  assign lastVisRow = (vctr == ScrnRows - 1);
  assign vFrontEnd  = (vctr == VSynStrt - 1);
  assign vSyncEnd   = (vctr == VSynStop - 1);
  assign frameLast  = (vctr == FramRows - 1);

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= init;
      lineEndReg    <= 1'b0;
      frameStartReg <= 1'b0;
      hsyncReg      <= 1'b0;
    end else begin
      lineEndReg    <= (hctr == LineCols - 2); // high on the last column
      frameStartReg <= (lineLast && frameLast) || (state == init);
      // hsync runs on blank lines too, so keep it apart from the state
      hsyncReg      <= hFrontEnd || (hsyncReg && !hSyncEnd);
      case (state)
        init:    state <= active; // counters are cleared during init
        active:  state <= activeEnd ? hFront : active;
        hFront:  state <= hFrontEnd ? hSync : hFront;
        hSync:   state <= hSyncEnd ? hBack : hSync;
        hBack:   if (lineLast) state <= lastVisRow ? vFront : active;
        vFront:  if (lineLast && vFrontEnd) state <= vSync;
        vSync:   if (lineLast && vSyncEnd) state <= vBack;
        vBack:   if (lineLast && frameLast) state <= active;
        default: state <= init;
      endcase
    end
  end

  always_comb begin
    ctl.init       = (state == init);
    ctl.active     = (state == active);
    ctl.lineEnd    = lineEndReg;
    ctl.frameStart = frameStartReg;
    ctl.hsyncLevel = hsyncReg;
    ctl.vsyncLevel = (state == vSync); // whole lines from column 0
  end

endmodule

// ==== logic/glyphFetch.sv ====
`timescale 1ns/1ps

module glyphFetch #(
  parameter int TextCols = 64,
  parameter int TextRows = 32,
  parameter int FontCols = 10,
  parameter int FontRows = 15
) (
  input  logic                                                      clk,
  input  logic                                                      reset,
  input  textVgaPkg::rasterCtl                                      ctl,
  input  int                                                        hctr,
  input  int                                                        vctr,
  output logic [$clog2(TextCols * TextRows)-1:0]                    textAddr,
  input  logic [textVgaPkg::CharWidth-1:0]                          textData,
  output logic [$clog2((2 ** textVgaPkg::CharWidth) * FontRows)-1:0] fontAddr,
  input  logic [FontCols-1:0]                                       fontData,
  output logic                                                      pixel
);
  import textVgaPkg::*;

  localparam int TextAddrWidth = $clog2(TextCols * TextRows);
  localparam int FontAddrWidth = $clog2((2 ** CharWidth) * FontRows);
  localparam int FetchCols     = TextCols * FontCols; // visible columns
  localparam int FetchRows     = TextRows * FontRows; // visible rows

  int   tcol;
  int   trow;
  int   grow;
  logic cellLast;  // last column of a cell
  logic cellWrap;  // first column of the next cell
  logic rowWrap;   // first line of a new text row
  logic lineReset;
  logic frameReset;
  logic loadGlyph;
  logic [FontCols-1:0] glyph;

  assign lineReset  = reset | ctl.init | ctl.lineEnd;
  assign frameReset = reset | ctl.init | ctl.frameStart;

  rangeCounter #(.Min(0), .Max(FontCols - 1), .Inc(1)) glyphColCtr (
    .clk, .reset(lineReset), .en(ctl.active),
    .count(), .nearFull(cellLast), .wrap(cellWrap)
  );

  rangeCounter #(.Min(0), .Max(TextCols - 1), .Inc(1)) textColCtr (
    .clk, .reset(lineReset), .en(cellLast),
    .count(tcol), .nearFull(), .wrap()
  );

  // glyph row steps only across visible lines
  rangeCounter #(.Min(0), .Max(FontRows - 1), .Inc(1)) glyphRowCtr (
    .clk, .reset(frameReset), .en(ctl.lineEnd && (vctr < FetchRows)),
    .count(grow), .nearFull(), .wrap(rowWrap)
  );

  rangeCounter #(.Min(0), .Max(TextRows - 1), .Inc(1)) textRowCtr (
    .clk, .reset(frameReset), .en(rowWrap),
    .count(trow), .nearFull(), .wrap()
  );

  // text read, then font read, then shifter load, one cycle each
  always_ff @(posedge clk) begin
    if (reset) begin
      textAddr  <= '0;
      fontAddr  <= '0;
      loadGlyph <= 1'b0;
    end else begin
      if (hctr < FetchCols) begin
        textAddr <= TextAddrWidth'(trow * TextCols + tcol); // held through blanking
      end
      fontAddr  <= FontAddrWidth'(int'(textData) * FontRows + grow);
      loadGlyph <= cellWrap;
    end
  end

  always_ff @(posedge clk) begin
    if (loadGlyph) begin
      glyph <= fontData;
    end else begin
      glyph <= glyph >> 1; // bit 0 is the leftmost pixel
    end
  end

  assign pixel = glyph[0];

endmodule

// ==== logic/textVgaTop.sv ====
`timescale 1ns/1ps

module textVgaTop #(
  parameter int ScrnCols = 640,
  parameter int ScrnRows = 480,
  parameter int TextCols = 64,
  parameter int TextRows = 32,
  parameter int FontCols = 10,
  parameter int FontRows = 15,
  parameter int HSynStrt = 656,
  parameter int HSynStop = 720,
  parameter int LineCols = 800,
  parameter int VSynStrt = 483,
  parameter int VSynStop = 487,
  parameter int FramRows = 501
) (
  input  logic                                                      clk,
  input  logic                                                      reset,
  output logic [$clog2(TextCols * TextRows)-1:0]                    textAddr,
  input  logic [textVgaPkg::CharWidth-1:0]                          textData,
  output logic [$clog2((2 ** textVgaPkg::CharWidth) * FontRows)-1:0] fontAddr,
  input  logic [FontCols-1:0]                                       fontData,
  output textVgaPkg::videoOut                                       video
);
  import textVgaPkg::*;

  localparam int PixelLatency = FontCols + 2; // text, font and shifter stages

  typedef struct packed {
    logic hsync;
    logic vsync;
    logic visible;
  } syncGroup;

  rasterCtl ctl;
  int       hctr;
  int       vctr;
  logic     lineLast;
  logic     counterReset;
  logic     pixel;
  syncGroup syncNow;
  syncGroup syncDly;

  assign counterReset = reset | ctl.init;

  rangeCounter #(.Min(0), .Max(LineCols - 1), .Inc(1)) hCounter (
    .clk, .reset(counterReset), .en(1'b1),
    .count(hctr), .nearFull(lineLast), .wrap()
  );

  rangeCounter #(.Min(0), .Max(FramRows - 1), .Inc(1)) vCounter (
    .clk, .reset(counterReset), .en(lineLast),
    .count(vctr), .nearFull(), .wrap()
  );

  rasterSequencer #(
    .ScrnCols(ScrnCols), .ScrnRows(ScrnRows),
    .HSynStrt(HSynStrt), .HSynStop(HSynStop), .LineCols(LineCols),
    .VSynStrt(VSynStrt), .VSynStop(VSynStop), .FramRows(FramRows)
  ) sequencer (
    .clk, .reset, .hctr, .vctr, .ctl
  );

  glyphFetch #(
    .TextCols(TextCols), .TextRows(TextRows),
    .FontCols(FontCols), .FontRows(FontRows)
  ) fetch (
    .clk, .reset, .ctl, .hctr, .vctr,
    .textAddr, .textData, .fontAddr, .fontData, .pixel
  );

  always_comb begin
    syncNow.hsync   = ctl.hsyncLevel;
    syncNow.vsync   = ctl.vsyncLevel;
    syncNow.visible = ctl.active;
  end

  // line up syncs and blanking with the pixel pipeline
  delayLine #(.Len(PixelLatency), .Width($bits(syncGroup))) syncDelay (
    .clk, .reset, .din(syncNow), .dout(syncDly)
  );

  always_comb begin
    video.red    = pixel & syncDly.visible;
    video.green  = pixel & syncDly.visible;
    video.blue   = pixel & syncDly.visible;
    video.hsyncN = ~syncDly.hsync;
    video.vsyncN = ~syncDly.vsync;
  end

endmodule

// ==== bench/videoModel.svh ====
`ifndef VIDEO_MODEL_SVH
`define VIDEO_MODEL_SVH

logic [CharWidth-1:0] textMem [TextCells];           // character codes, row-major cells
logic [FontCols-1:0]  fontMem [CharCount][FontRows]; // bit 0 is the leftmost pixel

function automatic videoOut makeVideo(logic pix, logic hsyncN, logic vsyncN);
  videoOut v;
  v.red    = pix; // monochrome, all guns alike
  v.green  = pix;
  v.blue   = pix;
  v.hsyncN = hsyncN;
  v.vsyncN = vsyncN;
  return v;
endfunction

// expected pixel at a raster position, blank outside the text area
function automatic logic referencePixel(int col, int row);
  int code;
  if (col >= ScrnCols || row >= ScrnRows) begin
    return 1'b0;
  end
  code = textMem[(row / FontRows) * TextCols + col / FontCols];
  return fontMem[code][row % FontRows][col % FontCols];
endfunction

task automatic checkVideo(string name, videoOut expected, videoOut actual);
  if (actual !== expected) begin
    $display("FAILED %s: expected %b actual %b (red green blue hsyncN vsyncN)",
             name, expected, actual);
    abortRun();
  end
endtask

task automatic checkCount(string name, int expected, int actual);
  if (actual != expected) begin
    $display("FAILED %s: expected %0d actual %0d", name, expected, actual);
    abortRun();
  end
endtask

`endif

// ==== bench/textVgaBench.sv ====
`timescale 1ns/1ps

module textVgaBench;
  import textVgaPkg::*;

  localparam int ScrnCols = 24;
  localparam int TextCols = 3;
  localparam int FontCols = 8;
  localparam int HSynStrt = 28;
  localparam int HSynStop = 32;
  localparam int LineCols = 44;
  localparam int ScrnRows = 12;
  localparam int TextRows = 3;
  localparam int FontRows = 4;
  localparam int VSynStrt = 13;
  localparam int VSynStop = 15;
  localparam int FramRows = 17;
  localparam int TextCells = TextCols * TextRows;
  localparam int CharCount = 2 ** CharWidth;
  localparam int FrameLen = LineCols * FramRows;
  localparam int CheckFrames = 2;
  localparam int TimeoutCycles = 3 * FrameLen + 200; // three frames plus margin

  logic clk;
  logic reset;
  logic [$clog2(TextCells)-1:0] textAddr;
  logic [CharWidth-1:0] textData;
  logic [$clog2(CharCount * FontRows)-1:0] fontAddr;
  logic [FontCols-1:0] fontData;
  videoOut video;

  videoOut prevVideo;
  logic hLocked;       // model column known
  logic vLocked;       // model row known
  int modelCol;
  int modelRow;
  int sampleIdx;
  int lastHFall;
  int lastVFall;
  int vFalls;
  int lockedCycles;    // samples since the first vsync fall
  int cycleCount;
  logic runDone;
  int unsigned seedValue;

  task automatic abortRun();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at first error");
  endtask

  `include "videoModel.svh"

  textVgaTop #(
    .ScrnCols(ScrnCols), .ScrnRows(ScrnRows), .TextCols(TextCols), .TextRows(TextRows),
    .FontCols(FontCols), .FontRows(FontRows), .HSynStrt(HSynStrt), .HSynStop(HSynStop),
    .LineCols(LineCols), .VSynStrt(VSynStrt), .VSynStop(VSynStop), .FramRows(FramRows)
  ) u_dut (
    .clk, .reset, .textAddr, .textData, .fontAddr, .fontData, .video
  );

  always #50 clk = ~clk;

  // memories answer within the cycle of the address
  always @(posedge clk) begin
    #1;
    if (textAddr >= TextCells) begin
      $display("text address %0d points past the last of %0d text cells",
               textAddr, TextCells);
      abortRun();
    end else begin
      textData = textMem[textAddr];
      fontData = fontMem[fontAddr / FontRows][fontAddr % FontRows];
    end
  end

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("timeout: two frames were not checked within %0d cycles", TimeoutCycles);
      abortRun();
    end
  end

  task automatic fillMemories();
    for (int i = 0; i < TextCells; i++) begin
      textMem[i] = CharWidth'($urandom);
    end
    for (int c = 0; c < CharCount; c++) begin
      for (int r = 0; r < FontRows; r++) begin
        fontMem[c][r] = FontCols'($urandom);
      end
    end
  endtask

  task automatic trackRaster();
    logic hFall;
    logic hRise;
    logic vFall;
    logic vRise;
    logic pix;
    logic hs;
    logic vs;
    videoOut seen;
    hFall = prevVideo.hsyncN && !video.hsyncN;
    hRise = !prevVideo.hsyncN && video.hsyncN;
    vFall = prevVideo.vsyncN && !video.vsyncN;
    vRise = !prevVideo.vsyncN && video.vsyncN;
    sampleIdx++;
    if (vLocked) lockedCycles++;
    if (hLocked) begin
      modelCol = (modelCol + 1) % LineCols;
      if (vLocked && modelCol == 0) modelRow = (modelRow + 1) % FramRows;
    end
    if (hFall) begin
      if (hLocked) begin
        checkCount("hsync period", LineCols, sampleIdx - lastHFall);
      end else begin
        hLocked  = 1'b1;
        modelCol = HSynStrt; // first fall marks the sync start column
      end
      lastHFall = sampleIdx;
    end
    if (hRise) checkCount("hsync low width", HSynStop - HSynStrt, sampleIdx - lastHFall);
    if (vFall) begin
      if (!hLocked) begin
        $display("vsync fell before any hsync pulse was seen");
        abortRun();
      end else begin
        checkCount("column at vsync fall", 0, modelCol);
        if (vLocked) begin
          checkCount("frame period", FrameLen, sampleIdx - lastVFall);
        end else begin
          vLocked      = 1'b1;
          modelRow     = VSynStrt;
          lockedCycles = 0;
        end
        lastVFall = sampleIdx;
        vFalls++;
      end
    end
    if (vRise) begin
      checkCount("vsync low width", (VSynStop - VSynStrt) * LineCols, sampleIdx - lastVFall);
    end
    hs = !(hLocked && modelCol >= HSynStrt && modelCol < HSynStop);
    vs = !(vLocked && modelRow >= VSynStrt && modelRow < VSynStop);
    pix = vLocked ? referencePixel(modelCol, modelRow) : 1'b0;
    if (vLocked || (hLocked && modelCol >= ScrnCols)) begin
      checkVideo($sformatf("video col %0d row %0d", modelCol, modelRow),
                 makeVideo(pix, hs, vs), video);
    end else begin
      seen       = video; // pixel rows unknown yet, syncs only
      seen.red   = 1'b0;
      seen.green = 1'b0;
      seen.blue  = 1'b0;
      checkVideo("syncs before raster lock", makeVideo(1'b0, hs, vs), seen);
    end
    prevVideo = video;
    if (vLocked && lockedCycles == CheckFrames * FrameLen) runDone = 1'b1;
  endtask

  // sample mid-cycle, away from the edges
  always @(negedge clk) begin
    if (reset) begin
      if (cycleCount > 0) begin // registers unknown before the first edge
        checkVideo("idle during reset", makeVideo(1'b0, 1'b1, 1'b1), video);
      end
    end else if (!runDone) begin
      trackRaster();
    end
  end

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    textData     = '0;
    fontData     = '0;
    prevVideo    = makeVideo(1'b0, 1'b1, 1'b1);
    hLocked      = 1'b0;
    vLocked      = 1'b0;
    modelCol     = 0;
    modelRow     = 0;
    sampleIdx    = 0;
    lastHFall    = 0;
    lastVFall    = 0;
    vFalls       = 0;
    lockedCycles = 0;
    cycleCount   = 0;
    runDone      = 1'b0;
    seedValue    = 32'h632c_8a2b;
    void'($urandom(seedValue));
    fillMemories();
    repeat (8) @(posedge clk);
    #1 reset = 1'b0;
    wait (runDone);
    checkCount("vsync falls seen", CheckFrames + 1, vFalls);
    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+bench
logic/textVgaPkg.sv
logic/rangeCounter.sv
logic/delayLine.sv
logic/rasterSequencer.sv
logic/glyphFetch.sv
logic/textVgaTop.sv
bench/textVgaBench.sv
